//--- design/dcache_pkg.sv
// dcache_pkg: address widths, set and way counts, address union, stored line struct

package dcache_pkg;

  // geometry
  localparam int num_ways    = 4;
  localparam int index_bits  = 4;
  localparam int offset_bits = 3;
  localparam int addr_bits   = 32;
  localparam int tag_bits    = addr_bits - index_bits - offset_bits;
  localparam int num_sets    = 1 << index_bits;

  typedef logic [index_bits-1:0] dcache_index_t;
  typedef logic [tag_bits-1:0]   dcache_tag_t;

  // one address word, seen whole or split into its fields
  typedef union packed {
    logic [addr_bits-1:0] raw;
    struct packed {
      dcache_tag_t             tag;
      dcache_index_t           index;
      logic [offset_bits-1:0]  offset;
    } fields;
  } dcache_addr_u;

  // one stored line, a single 64-bit word
  typedef struct packed {
    logic        valid;
    logic        dirty;
    dcache_tag_t tag;
    logic [63:0] data;
  } dcache_line_t;

endpackage

//--- design/dcache_port_if.sv
// dcache_port_if: lookup, write and victim signals between controller and line array

`timescale 1ns/10ps

interface dcache_port_if;
  import dcache_pkg::*;

  // request side, from the controller
  dcache_index_t index;
  dcache_tag_t   tag;
  logic          access;
  logic          wr_en;
  logic [63:0]   wr_data;
  logic          wr_dirty;

  // lookup results, combinational in the array
  logic          hit;
  logic [63:0]   hit_data;
  logic          victim_dirty;
  dcache_tag_t   victim_tag;
  logic [63:0]   victim_data;

  modport ctrl (
    output index, tag, access, wr_en, wr_data, wr_dirty,
    input  hit, hit_data, victim_dirty, victim_tag, victim_data
  );

  modport array (
    input  index, tag, access, wr_en, wr_data, wr_dirty,
    output hit, hit_data, victim_dirty, victim_tag, victim_data
  );

endinterface

//--- design/dcache_way.sv
// dcache_way: one way of 16 lines with tag compare and a single write port

`timescale 1ns/10ps

module dcache_way (
  input  logic                     clock,
  input  logic                     reset,
  input  dcache_pkg::dcache_index_t index,
  input  dcache_pkg::dcache_tag_t   tag,
  input  logic                     wr_en,
  input  dcache_pkg::dcache_line_t  wr_line,
  output logic                     hit,
  output dcache_pkg::dcache_line_t  line
);
  import dcache_pkg::*;

  // state bits per set
  logic [num_sets-1:0] valid_q;
  logic [num_sets-1:0] dirty_q;

  // tag and data storage
  dcache_tag_t tag_mem [num_sets];
  logic [63:0] data_mem [num_sets];

  // current line at the indexed set
  logic        cur_valid;
  logic        cur_dirty;
  dcache_tag_t cur_tag;
  logic [63:0] cur_data;

  assign cur_valid = valid_q[index];
  assign cur_dirty = dirty_q[index];
  assign cur_tag   = tag_mem[index];
  assign cur_data  = data_mem[index];

  // lookup
  assign hit = cur_valid && (cur_tag == tag);

  always_comb begin
    line.valid = cur_valid;
    line.dirty = cur_dirty;
    line.tag   = cur_tag;
    line.data  = cur_data;
  end

  // valid and dirty, cleared on reset
  always_ff @(posedge clock) begin
    if (reset) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else if (wr_en) begin
      valid_q[index] <= wr_line.valid;
      dirty_q[index] <= wr_line.dirty;
    end
  end

  // tag and data written together with the state bits
  always_ff @(posedge clock) begin
    if (wr_en) begin
      tag_mem[index]  <= wr_line.tag;
      data_mem[index] <= wr_line.data;
    end
  end

endmodule

//--- design/plru_tree.sv
// plru_tree: per-set three-bit pseudo-LRU tree, victim decode and touch update

`timescale 1ns/10ps

module plru_tree (
  input  logic                     clock,
  input  logic                     reset,
  input  dcache_pkg::dcache_index_t index,
  input  logic                     touch,
  input  logic [3:0]               touch_way,
  output logic [3:0]               victim_way
);
  import dcache_pkg::*;

  // a picks the half, b picks within ways 0/1, c within ways 2/3
  logic [num_sets-1:0] a_q;
  logic [num_sets-1:0] b_q;
  logic [num_sets-1:0] c_q;

  logic a_cur;
  logic b_cur;
  logic c_cur;
  logic low_half;

  assign a_cur = a_q[index];
  assign b_cur = b_q[index];
  assign c_cur = c_q[index];

  // victim for the indexed set, always one-hot
  assign victim_way[0] = ~a_cur & ~b_cur;
  assign victim_way[1] = ~a_cur &  b_cur;
  assign victim_way[2] =  a_cur & ~c_cur;
  assign victim_way[3] =  a_cur &  c_cur;

  // touched way sits in ways 0/1
  assign low_half = touch_way[0] | touch_way[1];

  // point the tree away from the touched way
  always_ff @(posedge clock) begin
    if (reset) begin
      a_q <= '0;
      b_q <= '0;
      c_q <= '0;
    end else if (touch) begin
      a_q[index] <= low_half;
      if (low_half) begin
        b_q[index] <= touch_way[0];
      end else begin
        c_q[index] <= touch_way[2];
      end
    end
  end

  // the array must name exactly one way when it touches
  touch_way_onehot: assert property (
    @(posedge clock) disable iff (reset)
    touch |-> $onehot(touch_way)
  ) else $error("plru_tree: touch_way %b is not one-hot", touch_way);

endmodule

//--- design/dcache_array.sv
// dcache_array: four ways and the LRU tree, hit and victim select, write steering

`timescale 1ns/10ps

module dcache_array (
  input logic         clock,
  input logic         reset,
  dcache_port_if.array port
);
  import dcache_pkg::*;

  // per-way lookup results
  logic [num_ways-1:0] hit_way;
  dcache_line_t        way_line [num_ways];

  // LRU victim and the way that takes the write
  logic [num_ways-1:0] victim_way;
  logic [num_ways-1:0] write_way;

  dcache_line_t wr_line;
  dcache_line_t victim_line;
  logic         touch;

  // every written line is valid
  always_comb begin
    wr_line.valid = 1'b1;
    wr_line.dirty = port.wr_dirty;
    wr_line.tag   = port.tag;
    wr_line.data  = port.wr_data;
  end

  for (genvar w = 0; w < num_ways; w++) begin : g_way
    dcache_way way_i (
      .clock   (clock),
      .reset   (reset),
      .index   (port.index),
      .tag     (port.tag),
      .wr_en   (port.wr_en & write_way[w]),
      .wr_line (wr_line),
      .hit     (hit_way[w]),
      .line    (way_line[w])
    );
  end

  assign port.hit = |hit_way;

  // hit data and victim line, both selects are one-hot
  always_comb begin
    port.hit_data = '0;
    victim_line   = '0;
    for (int w = 0; w < num_ways; w++) begin
      if (hit_way[w]) begin
        port.hit_data = port.hit_data | way_line[w].data;
      end
      if (victim_way[w]) begin
        victim_line = way_line[w];
      end
    end
  end

  // only a valid dirty victim needs writeback
  assign port.victim_dirty = victim_line.valid & victim_line.dirty;
  assign port.victim_tag   = victim_line.tag;
  assign port.victim_data  = victim_line.data;

  // hit way is rewritten in place, else the LRU way is replaced
  assign write_way = port.hit ? hit_way : victim_way;

  // a load or store hit touches, so does every write
  assign touch = (port.access & port.hit) | port.wr_en;

  plru_tree plru_i (
    .clock      (clock),
    .reset      (reset),
    .index      (port.index),
    .touch      (touch),
    .touch_way  (write_way),
    .victim_way (victim_way)
  );

  // a tag lives in at most one way of a set
  single_hit: assert property (
    @(posedge clock) disable iff (reset)
    port.access |-> $onehot0(hit_way)
  ) else $error("dcache_array: several ways hit, hit_way %b", hit_way);

endmodule

//--- design/dcache_ctrl.sv
// dcache_ctrl: request decode, write and touch control, registered results and writeback

`timescale 1ns/10ps

module dcache_ctrl (
  input  logic         clock,
  input  logic         reset,
  input  logic         load_req,
  input  logic         store_req,
  input  logic         fill_req,
  input  logic [31:0]  load_addr,
  input  logic [31:0]  store_addr,
  input  logic [31:0]  fill_addr,
  input  logic [63:0]  store_data,
  input  logic [63:0]  fill_data,
  dcache_port_if.ctrl  port,
  output logic         load_done,
  output logic         load_hit,
  output logic [63:0]  load_data,
  output logic         store_done,
  output logic         store_hit,
  output logic         fill_done,
  output logic         evict_valid,
  output logic [31:0]  evict_addr,
  output logic [63:0]  evict_data
);
  import dcache_pkg::*;

  dcache_addr_u req_addr;
  dcache_addr_u wb_addr;

  // address of the present request
  always_comb begin
    req_addr.raw = load_addr;
    if (store_req) begin
      req_addr.raw = store_addr;
    end else if (fill_req) begin
      req_addr.raw = fill_addr;
    end
  end

  assign port.index    = req_addr.fields.index;
  assign port.tag      = req_addr.fields.tag;
  assign port.access   = load_req | store_req | fill_req;
  // store without a hit does not allocate
  assign port.wr_en    = fill_req | (store_req & port.hit);
  assign port.wr_data  = fill_req ? fill_data : store_data;
  assign port.wr_dirty = store_req;

  // writeback address, victim tag at the same set
  always_comb begin
    wb_addr.fields.tag    = port.victim_tag;
    wb_addr.fields.index  = req_addr.fields.index;
    wb_addr.fields.offset = '0;
  end

  // done strobes and hit flags
  always_ff @(posedge clock) begin
    if (reset) begin
      load_done   <= 1'b0;
      load_hit    <= 1'b0;
      store_done  <= 1'b0;
      store_hit   <= 1'b0;
      fill_done   <= 1'b0;
      evict_valid <= 1'b0;
    end else begin
      load_done   <= load_req;
      load_hit    <= load_req & port.hit;
      store_done  <= store_req;
      store_hit   <= store_req & port.hit;
      fill_done   <= fill_req;
      evict_valid <= fill_req & ~port.hit & port.victim_dirty;
    end
  end

  // result words, zero on a load miss
  always_ff @(posedge clock) begin
    if (load_req) begin
      load_data <= port.hit ? port.hit_data : 64'd0;
    end
    if (fill_req) begin
      evict_addr <= wb_addr.raw;
      evict_data <= port.victim_data;
    end
  end

  // environment issues one request per cycle at most
  one_request: assert property (
    @(posedge clock) disable iff (reset)
    $onehot0({load_req, store_req, fill_req})
  ) else $error("dcache_ctrl: more than one request strobe high");

endmodule

//--- design/dcache_top.sv
// dcache_top: data cache top level, controller and line array joined by the port interface

`timescale 1ns/10ps

module dcache_top (
  input  logic         clock,
  input  logic         reset,
  input  logic         load_req,
  input  logic         store_req,
  input  logic         fill_req,
  input  logic [31:0]  load_addr,
  input  logic [31:0]  store_addr,
  input  logic [31:0]  fill_addr,
  input  logic [63:0]  store_data,
  input  logic [63:0]  fill_data,
  output logic         load_done,
  output logic         load_hit,
  output logic [63:0]  load_data,
  output logic         store_done,
  output logic         store_hit,
  output logic         fill_done,
  output logic         evict_valid,
  output logic [31:0]  evict_addr,
  output logic [63:0]  evict_data
);

  dcache_port_if port_if ();

  dcache_ctrl ctrl_i (
    .clock       (clock),
    .reset       (reset),
    .load_req    (load_req),
    .store_req   (store_req),
    .fill_req    (fill_req),
    .load_addr   (load_addr),
    .store_addr  (store_addr),
    .fill_addr   (fill_addr),
    .store_data  (store_data),
    .fill_data   (fill_data),
    .port        (port_if.ctrl),
    .load_done   (load_done),
    .load_hit    (load_hit),
    .load_data   (load_data),
    .store_done  (store_done),
    .store_hit   (store_hit),
    .fill_done   (fill_done),
    .evict_valid (evict_valid),
    .evict_addr  (evict_addr),
    .evict_data  (evict_data)
  );

  dcache_array array_i (
    .clock (clock),
    .reset (reset),
    .port  (port_if.array)
  );

endmodule

//--- bench/dcache_checker.sv
// dcache_checker: compares registered DUT results with the expected row, counts errors

`timescale 1ns/10ps

module dcache_checker (
  input  logic        clock,
  input  logic        reset,
  input  logic        load_done,
  input  logic        load_hit,
  input  logic [63:0] load_data,
  input  logic        store_done,
  input  logic        store_hit,
  input  logic        fill_done,
  input  logic        evict_valid,
  input  logic [31:0] evict_addr,
  input  logic [63:0] evict_data,
  input  logic [1:0]  exp_op,
  input  logic        exp_hit,
  input  logic [63:0] exp_data,
  input  logic        exp_evict,
  input  logic [31:0] exp_eaddr,
  input  logic [63:0] exp_edata,
  output int          errors
);

  localparam logic [1:0] op_idle  = 2'd0;
  localparam logic [1:0] op_load  = 2'd1;
  localparam logic [1:0] op_store = 2'd2;
  localparam logic [1:0] op_fill  = 2'd3;

  // expectation of the request the DUT took at the last edge
  logic [1:0]  pend_op;
  logic        pend_hit;
  logic [63:0] pend_data;
  logic        pend_evict;
  logic [31:0] pend_eaddr;
  logic [63:0] pend_edata;

  int checks = 0;
  int value_errors = 0;
  int strobe_errors = 0;

  assign errors = value_errors + strobe_errors;

  task automatic compare_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
    checks++;
    if (actual !== expected) begin
      value_errors++;
      $display("Error at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
    end
  endtask

  task automatic check_strobe(input string name, input logic seen, input logic wanted);
    if (seen !== wanted) begin
      strobe_errors++;
      if (wanted) begin
        $display("%s did not rise at %0t ns, one cycle after its request", name, $time);
      end else begin
        $display("%s rose at %0t ns with no request the cycle before", name, $time);
      end
    end
  endtask

  task print_counts;
    $display("checks: %0d, value errors: %0d, strobe errors: %0d",
             checks, value_errors, strobe_errors);
  endtask

  // follow the strobe into the DUT's sampling edge
  always @(posedge clock) begin
    if (reset) begin
      pend_op <= op_idle;
    end else begin
      pend_op    <= exp_op;
      pend_hit   <= exp_hit;
      pend_data  <= exp_data;
      pend_evict <= exp_evict;
      pend_eaddr <= exp_eaddr;
      pend_edata <= exp_edata;
    end
  end

  // results are registered, so mid-cycle they are stable
  always @(negedge clock) begin
    if (!reset) begin
      check_strobe("load_done", load_done, pend_op == op_load);
      check_strobe("store_done", store_done, pend_op == op_store);
      check_strobe("fill_done", fill_done, pend_op == op_fill);
      compare_value("evict_valid", (pend_op == op_fill) && pend_evict, evict_valid);
      if (pend_op == op_load) begin
        compare_value("load_hit", pend_hit, load_hit);
        compare_value("load_data", pend_data, load_data);
      end
      if (pend_op == op_store) begin
        compare_value("store_hit", pend_hit, store_hit);
      end
      if (pend_op == op_fill && pend_evict) begin
        compare_value("evict_addr", pend_eaddr, evict_addr);
        compare_value("evict_data", pend_edata, evict_data);
      end
    end
  end

endmodule

//--- bench/dcache_tb.sv
// dcache_tb: clock, reset, stimulus table with expected results, DUT, checker and watchdog

`timescale 1ns/10ps

module dcache_tb;

  localparam logic [1:0] op_load  = 2'd1;
  localparam logic [1:0] op_store = 2'd2;
  localparam logic [1:0] op_fill  = 2'd3;

  typedef struct packed {
    logic [1:0]  op;
    logic [31:0] addr;
    logic [63:0] data;
    logic        hit;
    logic [63:0] exp_data;
    logic        evict;
    logic [31:0] eaddr;
    logic [63:0] edata;
  } row_t;

  logic        clock;
  logic        reset;
  logic        load_req;
  logic        store_req;
  logic        fill_req;
  logic [31:0] load_addr;
  logic [31:0] store_addr;
  logic [31:0] fill_addr;
  logic [63:0] store_data;
  logic [63:0] fill_data;
  logic        load_done;
  logic        load_hit;
  logic [63:0] load_data;
  logic        store_done;
  logic        store_hit;
  logic        fill_done;
  logic        evict_valid;
  logic [31:0] evict_addr;
  logic [63:0] evict_data;
  logic [1:0]  exp_op;
  logic        exp_hit;
  logic [63:0] exp_data;
  logic        exp_evict;
  logic [31:0] exp_eaddr;
  logic [63:0] exp_edata;
  int          errors;

  row_t        rows[$];
  logic [63:0] d [28];
  int unsigned seed;
  logic        table_ready = 1'b0;

  dcache_top dut_i (.*);

  dcache_checker checker_i (.*);

  // tag above index above byte offset
  function automatic logic [31:0] addr_of(input logic [24:0] tag, input logic [3:0] index,
                                          input logic [2:0] offset);
    return {tag, index, offset};
  endfunction

  task automatic load_row(input logic [31:0] addr, input logic hit, input logic [63:0] data);
    rows.push_back({op_load, addr, 64'd0, hit, data, 1'b0, 32'd0, 64'd0});
  endtask

  task automatic store_row(input logic [31:0] addr, input logic [63:0] data, input logic hit);
    rows.push_back({op_store, addr, data, hit, 64'd0, 1'b0, 32'd0, 64'd0});
  endtask

  task automatic fill_row(input logic [31:0] addr, input logic [63:0] data, input logic evict,
                          input logic [31:0] eaddr, input logic [63:0] edata);
    rows.push_back({op_fill, addr, data, 1'b0, 64'd0, evict, eaddr, edata});
  endtask

  task automatic build_table;
    // cold misses in set 1, then fill, hit, store hit and store miss
    load_row(addr_of(25'h5, 4'd1, 3'd0), 1'b0, 64'd0);
    load_row(addr_of(25'h1abcd, 4'd15, 3'd4), 1'b0, 64'd0);
    fill_row(addr_of(25'h5, 4'd1, 3'd0), d[0], 1'b0, 32'd0, 64'd0);
    load_row(addr_of(25'h5, 4'd1, 3'd6), 1'b1, d[0]);
    store_row(addr_of(25'h5, 4'd1, 3'd0), d[1], 1'b1);
    load_row(addr_of(25'h5, 4'd1, 3'd0), 1'b1, d[1]);
    store_row(addr_of(25'h6, 4'd1, 3'd0), d[2], 1'b0);
    load_row(addr_of(25'h6, 4'd1, 3'd0), 1'b0, 64'd0);
    rows.push_back('0);
    // tree points at way 2, then 1, 3 and finally the dirty way 0
    fill_row(addr_of(25'h7, 4'd1, 3'd0), d[3], 1'b0, 32'd0, 64'd0);
    fill_row(addr_of(25'h8, 4'd1, 3'd0), d[4], 1'b0, 32'd0, 64'd0);
    fill_row(addr_of(25'h9, 4'd1, 3'd0), d[5], 1'b0, 32'd0, 64'd0);
    fill_row(addr_of(25'ha, 4'd1, 3'd2), d[6], 1'b1, addr_of(25'h5, 4'd1, 3'd0), d[1]);
    fill_row(addr_of(25'hb, 4'd1, 3'd0), d[7], 1'b0, 32'd0, 64'd0);
    load_row(addr_of(25'h5, 4'd1, 3'd0), 1'b0, 64'd0);
    // a load hit on way 0 of set 3 moves the victim to way 2
    fill_row(addr_of(25'h20, 4'd3, 3'd0), d[8], 1'b0, 32'd0, 64'd0);
    fill_row(addr_of(25'h21, 4'd3, 3'd0), d[9], 1'b0, 32'd0, 64'd0);
    fill_row(addr_of(25'h22, 4'd3, 3'd0), d[10], 1'b0, 32'd0, 64'd0);
    fill_row(addr_of(25'h23, 4'd3, 3'd0), d[11], 1'b0, 32'd0, 64'd0);
    load_row(addr_of(25'h20, 4'd3, 3'd0), 1'b1, d[8]);
    fill_row(addr_of(25'h24, 4'd3, 3'd0), d[12], 1'b0, 32'd0, 64'd0);
    load_row(addr_of(25'h21, 4'd3, 3'd0), 1'b0, 64'd0);
    load_row(addr_of(25'h20, 4'd3, 3'd0), 1'b1, d[8]);
    load_row(addr_of(25'h22, 4'd3, 3'd0), 1'b1, d[10]);
    // fifth clean fill in set 2 replaces the first
    fill_row(addr_of(25'h40, 4'd2, 3'd0), d[13], 1'b0, 32'd0, 64'd0);
    fill_row(addr_of(25'h41, 4'd2, 3'd0), d[14], 1'b0, 32'd0, 64'd0);
    fill_row(addr_of(25'h42, 4'd2, 3'd0), d[15], 1'b0, 32'd0, 64'd0);
    fill_row(addr_of(25'h43, 4'd2, 3'd0), d[16], 1'b0, 32'd0, 64'd0);
    fill_row(addr_of(25'h44, 4'd2, 3'd0), d[17], 1'b0, 32'd0, 64'd0);
    load_row(addr_of(25'h40, 4'd2, 3'd0), 1'b0, 64'd0);
    load_row(addr_of(25'h41, 4'd2, 3'd0), 1'b1, d[14]);
    // dirty way 0 of set 4 is the victim when refilled in place
    fill_row(addr_of(25'h30, 4'd4, 3'd0), d[18], 1'b0, 32'd0, 64'd0);
    store_row(addr_of(25'h30, 4'd4, 3'd0), d[19], 1'b1);
    fill_row(addr_of(25'h31, 4'd4, 3'd0), d[21], 1'b0, 32'd0, 64'd0);
    fill_row(addr_of(25'h32, 4'd4, 3'd0), d[22], 1'b0, 32'd0, 64'd0);
    fill_row(addr_of(25'h33, 4'd4, 3'd0), d[23], 1'b0, 32'd0, 64'd0);
    fill_row(addr_of(25'h30, 4'd4, 3'd0), d[20], 1'b0, 32'd0, 64'd0);
    load_row(addr_of(25'h30, 4'd4, 3'd0), 1'b1, d[20]);
    // way 0 comes round again and is now clean
    fill_row(addr_of(25'h34, 4'd4, 3'd0), d[24], 1'b0, 32'd0, 64'd0);
    fill_row(addr_of(25'h35, 4'd4, 3'd0), d[25], 1'b0, 32'd0, 64'd0);
    fill_row(addr_of(25'h36, 4'd4, 3'd0), d[26], 1'b0, 32'd0, 64'd0);
    fill_row(addr_of(25'h37, 4'd4, 3'd0), d[27], 1'b0, 32'd0, 64'd0);
    load_row(addr_of(25'h30, 4'd4, 3'd0), 1'b0, 64'd0);
  endtask

  task automatic drive_row(input row_t r);
    load_req   <= (r.op == op_load);
    store_req  <= (r.op == op_store);
    fill_req   <= (r.op == op_fill);
    load_addr  <= r.addr;
    store_addr <= r.addr;
    fill_addr  <= r.addr;
    store_data <= r.data;
    fill_data  <= r.data;
    exp_op     <= r.op;
    exp_hit    <= r.hit;
    exp_data   <= r.exp_data;
    exp_evict  <= r.evict;
    exp_eaddr  <= r.eaddr;
    exp_edata  <= r.edata;
  endtask

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  initial begin
    seed = $urandom(92);
    reset = 1'b1;
    load_req = 1'b0;
    store_req = 1'b0;
    fill_req = 1'b0;
    load_addr = '0;
    store_addr = '0;
    fill_addr = '0;
    store_data = '0;
    fill_data = '0;
    exp_op = '0;
    exp_hit = 1'b0;
    exp_data = '0;
    exp_evict = 1'b0;
    exp_eaddr = '0;
    exp_edata = '0;
    for (int k = 0; k < 28; k++) begin
      d[k] = {$urandom, $urandom};
    end
    build_table();
    table_ready = 1'b1;
    repeat (10) @(posedge clock);
    reset <= 1'b0;
    foreach (rows[i]) begin
      drive_row(rows[i]);
      @(posedge clock);
    end
    drive_row('0);
    repeat (3) @(posedge clock);
    checker_i.print_counts();
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  // watchdog allows twice the table length plus a reset margin
  initial begin
    wait (table_ready);
    #((rows.size() + 20) * 8 * 2);
    $display("timeout: the stimulus table did not finish in time");
    $display(">>> FAIL");
    $finish;
  end

endmodule

//--- sim.f
design/dcache_pkg.sv
design/dcache_port_if.sv
design/dcache_way.sv
design/plru_tree.sv
design/dcache_array.sv
design/dcache_ctrl.sv
design/dcache_top.sv
bench/dcache_checker.sv
bench/dcache_tb.sv
